//--- rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Major opcodes
    localparam opcode_t OP_R3    = 7'b0110011;
    localparam opcode_t OP_IMM   = 7'b0010011;
    localparam opcode_t OP_LUI   = 7'b0110111;
    localparam opcode_t OP_AUIPC = 7'b0010111;
    localparam opcode_t OP_JAL   = 7'b1101111;
    localparam opcode_t OP_JALR  = 7'b1100111;
    localparam opcode_t OP_BR    = 7'b1100011;
    localparam opcode_t OP_LD    = 7'b0000011;
    localparam opcode_t OP_ST    = 7'b0100011;

    // ALU group funct3
    localparam funct3_t F3_ADD  = 3'b000; // ADD and SUB
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101; // SRL and SRA
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // Branch group funct3
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        A_RS1,
        A_PC,
        A_ZERO
    } op_a_sel_e;

endpackage

//--- fetch_unit.sv
module fetch_unit import rv_pkg::*; #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    input  logic  imem_we,
    input  word_t imem_addr,
    input  word_t imem_wdata,
    input  word_t next_pc,
    output word_t pc,
    output word_t inst
);

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    typedef logic [IDX_W-1:0] imem_idx_t;

    word_t     imem [IMEM_DEPTH];
    word_t     pc_q;
    imem_idx_t wr_idx;
    imem_idx_t rd_idx;

    assign wr_idx = imem_addr[IDX_W-1:0];
    assign rd_idx = pc_q[IDX_W+1:2]; // Word index wraps at IMEM_DEPTH

    // Load port from the testbench
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[wr_idx] <= imem_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (run) begin
            pc_q <= next_pc;
        end
    end

    assign pc   = pc_q;
    assign inst = imem[rd_idx]; // Combinational read

endmodule

//--- inst_decoder.sv
module inst_decoder import rv_pkg::*; (
    input  word_t     inst,
    output reg_idx_t  rs1,
    output reg_idx_t  rs2,
    output reg_idx_t  rd,
    output funct3_t   funct3,
    output word_t     imm,
    output alu_op_e   alu_op,
    output op_a_sel_e op_a_sel,
    output logic      op_b_imm,
    output logic      reg_we,
    output logic      is_branch,
    output logic      is_jal,
    output logic      is_jalr
);

    opcode_t opcode;
    funct7_t funct7;
    word_t   imm_i;
    word_t   imm_u;
    word_t   imm_j;
    word_t   imm_b;
    alu_op_e alu_fn;
    logic    wb_op;

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    // Operation for R-type and OP-IMM
    always_comb begin
        case (funct3)
            F3_ADD:  alu_fn = (opcode == OP_R3 && funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:  alu_fn = ALU_SLL;
            F3_SLT:  alu_fn = ALU_SLT;
            F3_SLTU: alu_fn = ALU_SLTU;
            F3_XOR:  alu_fn = ALU_XOR;
            F3_SR:   alu_fn = funct7[5] ? ALU_SRA : ALU_SRL; // SRAI too
            F3_OR:   alu_fn = ALU_OR;
            default: alu_fn = ALU_AND;
        endcase
    end

    always_comb begin
        imm       = '0;
        alu_op    = ALU_ADD;
        op_a_sel  = A_RS1;
        op_b_imm  = 1'b0;
        wb_op     = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        case (opcode)
            OP_R3: begin
                alu_op = alu_fn;
                wb_op  = 1'b1;
            end
            OP_IMM: begin
                imm      = imm_i;
                alu_op   = alu_fn;
                op_b_imm = 1'b1;
                wb_op    = 1'b1;
            end
            OP_LUI: begin
                imm      = imm_u;
                alu_op   = ALU_PASS_B;
                op_a_sel = A_ZERO;
                op_b_imm = 1'b1;
                wb_op    = 1'b1;
            end
            OP_AUIPC: begin
                imm      = imm_u;
                op_a_sel = A_PC;
                op_b_imm = 1'b1;
                wb_op    = 1'b1;
            end
            OP_JAL: begin
                imm      = imm_j;
                op_a_sel = A_PC;
                op_b_imm = 1'b1;
                wb_op    = 1'b1;
                is_jal   = 1'b1;
            end
            OP_JALR: begin
                imm      = imm_i;
                op_b_imm = 1'b1; // Target computed in the ALU
                wb_op    = 1'b1;
                is_jalr  = 1'b1;
            end
            OP_BR: begin
                imm       = imm_b;
                is_branch = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign reg_we = wb_op && (rd != '0);

endmodule

//--- reg_file.sv
module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  word_t    wdata,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- alu.sv
module alu import rv_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // Upper bits of b ignored for shifts

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SLT: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                result = {31'b0, a < b};
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = word_t'($signed(a) >>> shamt);
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_PASS_B: begin
                result = b; // LUI
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- branch_unit.sv
module branch_unit import rv_pkg::*; (
    input  word_t   pc,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    input  word_t   imm,
    input  word_t   alu_result,
    input  funct3_t funct3,
    input  logic    is_branch,
    input  logic    is_jal,
    input  logic    is_jalr,
    output word_t   next_pc
);

    logic taken;

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = (rs1_data == rs2_data);
            F3_BNE:  taken = (rs1_data != rs2_data);
            F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            F3_BLTU: taken = (rs1_data < rs2_data);
            F3_BGEU: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0; // Reserved encodings fall through
        endcase
    end

    always_comb begin
        if (is_jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (is_jal || (is_branch && taken)) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

endmodule

//--- rv_core.sv
module rv_core import rv_pkg::*; #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     imem_we,
    input  word_t    imem_addr,
    input  word_t    imem_wdata,
    input  logic     run,
    output logic     retire_valid,
    output word_t    retire_pc,
    output reg_idx_t retire_rd,
    output logic     retire_we,
    output word_t    retire_data
);

    word_t     pc;
    word_t     inst;
    word_t     next_pc;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    funct3_t   funct3;
    word_t     imm;
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    logic      op_b_imm;
    logic      reg_we;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     op_a;
    word_t     op_b;
    word_t     alu_result;
    word_t     wb_data;

    fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .clk, .rst_n, .run, .imem_we, .imem_addr, .imem_wdata, .next_pc, .pc, .inst
    );

    inst_decoder u_dec (
        .inst, .rs1, .rs2, .rd, .funct3, .imm, .alu_op, .op_a_sel, .op_b_imm,
        .reg_we, .is_branch, .is_jal, .is_jalr
    );

    reg_file u_rf (
        .clk, .rst_n, .we(run && reg_we), .rs1, .rs2, .rd, .wdata(wb_data),
        .rs1_data, .rs2_data
    );

    always_comb begin
        case (op_a_sel)
            A_RS1:   op_a = rs1_data;
            A_PC:    op_a = pc;
            default: op_a = '0;
        endcase
    end

    assign op_b = op_b_imm ? imm : rs2_data;

    alu u_alu (.op(alu_op), .a(op_a), .b(op_b), .result(alu_result));

    branch_unit u_br (
        .pc, .rs1_data, .rs2_data, .imm, .alu_result, .funct3, .is_branch, .is_jal,
        .is_jalr, .next_pc
    );

    assign wb_data = (is_jal || is_jalr) ? pc + 32'd4 : alu_result; // Link address

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            retire_valid <= run;
            retire_we    <= run && reg_we;
        end
    end

    // Trace payload
    always_ff @(posedge clk) begin
        if (run) begin
            retire_pc   <= pc;
            retire_rd   <= rd;
            retire_data <= wb_data;
        end
    end

endmodule

//--- rv_core_assert.sv
module rv_core_assert import rv_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     run,
    input logic     retire_valid,
    input word_t    retire_pc,
    input reg_idx_t retire_rd,
    input logic     retire_we
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // A retirement needs run at the edge before
    valid_after_run: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> $past(run))
    else begin
        fail_count++;
        $error("retire_valid high without run at the previous edge");
    end

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        retire_we |-> (retire_rd != 5'd0))
    else begin
        fail_count++;
        $error("retire_we high with retire_rd zero");
    end

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> (retire_pc[1:0] == 2'b00))
    else begin
        fail_count++;
        $error("retire_pc not word aligned");
    end

endmodule

bind rv_core rv_core_assert u_assert (
    .clk(clk), .rst_n(rst_n), .run(run), .retire_valid(retire_valid),
    .retire_pc(retire_pc), .retire_rd(retire_rd), .retire_we(retire_we)
);

//--- tb_rv_core.sv
module tb_rv_core import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_WORDS    = 256;
    localparam int RESET_CYCLES  = 10;
    localparam int RUN_CYCLES    = 600;
    localparam int RETIRE_TARGET = 500;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + PROG_WORDS + 2 + RUN_CYCLES;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     imem_we;
    word_t    imem_addr;
    word_t    imem_wdata;
    logic     run;
    logic     retire_valid;
    word_t    retire_pc;
    reg_idx_t retire_rd;
    logic     retire_we;
    word_t    retire_data;

    word_t prog [PROG_WORDS];
    word_t m_regs [32]; // Reference register state
    word_t m_pc;
    word_t rng_state = 32'h4089674f;
    int    cycle_count = 0;

    rv_core #(.IMEM_DEPTH(PROG_WORDS)) u_dut (
        .clk(clk), .rst_n(rst_n), .imem_we(imem_we), .imem_addr(imem_addr),
        .imem_wdata(imem_wdata), .run(run), .retire_valid(retire_valid),
        .retire_pc(retire_pc), .retire_rd(retire_rd), .retire_we(retire_we),
        .retire_data(retire_data)
    );

    always #2 clk = ~clk;

    function automatic word_t next_random();
        word_t x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic word_t r_type(funct7_t f7, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3,
                                     reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_R3};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, funct3_t f3,
                                     reg_idx_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t u_type(logic [19:0] imm, reg_idx_t rd, opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic word_t b_type(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BR};
    endfunction

    function automatic word_t j_type(logic [20:0] off, reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t random_inst(int idx);
        word_t   r;
        word_t   s;
        word_t   w;
        word_t   target;
        funct3_t f3;
        funct7_t f7;
        r  = next_random();
        s  = next_random();
        f3 = s[14:12];
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                f7 = ((f3 == F3_ADD || f3 == F3_SR) && s[30]) ? 7'h20 : 7'h00;
                w  = r_type(f7, s[24:20], s[19:15], f3, s[11:7]);
            end
            4'd5, 4'd6, 4'd7, 4'd8: begin
                if (f3 == F3_SLL) begin
                    w = i_type({7'h00, s[24:20]}, s[19:15], f3, s[11:7], OP_IMM);
                end else if (f3 == F3_SR) begin
                    w = i_type({s[30] ? 7'h20 : 7'h00, s[24:20]}, s[19:15], f3, s[11:7], OP_IMM);
                end else begin
                    w = i_type(s[31:20], s[19:15], f3, s[11:7], OP_IMM);
                end
            end
            4'd9:  w = u_type(s[31:12], s[11:7], OP_LUI);
            4'd10: w = u_type(s[31:12], s[11:7], OP_AUIPC);
            4'd11, 4'd12: begin
                f3 = (s[14:13] == 2'b01) ? {2'b00, s[12]} : s[14:12]; // Skip reserved codes
                w  = b_type(s[0] ? 13'd12 : 13'd8, s[1] ? s[19:15] : s[24:20], s[19:15], f3);
            end
            4'd13: w = j_type(21'd8, s[11:7]);
            4'd14: begin
                target = ((idx + 1 + int'(s[1:0])) % PROG_WORDS) * 4 + s[2]; // Odd on purpose
                w = i_type(target[11:0], 5'd0, 3'd0, s[11:7], OP_JALR);
            end
            default: begin
                case (s[1:0])
                    2'd0:    w = {s[31:7], OP_LD};
                    2'd1:    w = {s[31:7], OP_ST};
                    2'd2:    w = {s[31:7], 7'b0001111}; // FENCE
                    default: w = {s[31:7], 7'b1110011}; // SYSTEM
                endcase
            end
        endcase
        return w;
    endfunction

    task automatic build_program();
        word_t r;
        for (int k = 1; k < 32; k++) begin
            r = next_random();
            prog[2*k-2] = u_type(r[31:12], reg_idx_t'(k), OP_LUI);
            prog[2*k-1] = i_type(r[11:0], reg_idx_t'(k), F3_ADD, reg_idx_t'(k), OP_IMM);
        end
        for (int i = 62; i < PROG_WORDS; i++) begin
            prog[i] = random_inst(i);
        end
    endtask

    function automatic word_t alu_model(funct3_t f3, logic alt, logic is_reg, word_t a, word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            F3_ADD:  return (alt && is_reg) ? a - b : a + b;
            F3_SLL:  return a << sh;
            F3_SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  return a ^ b;
            F3_SR:   return alt ? (a >> sh) | ({32{a[31]}} << (5'd31 - sh)) : a >> sh;
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(funct3_t f3, word_t a, word_t b);
        logic lt_s;
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return lt_s;
            F3_BGE:  return !lt_s;
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("** Error at %0d ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // One instruction of the reference model against the trace
    task automatic check_retirement();
        word_t    ins;
        word_t    a;
        word_t    b;
        word_t    imm_i;
        word_t    res;
        word_t    npc;
        reg_idx_t rd;
        logic     we;
        ins   = prog[m_pc[9:2]];
        rd    = ins[11:7];
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        res   = '0;
        we    = 1'b0;
        npc   = m_pc + 4;
        case (ins[6:0])
            OP_R3: begin
                res = alu_model(ins[14:12], ins[30], 1'b1, a, b);
                we  = 1'b1;
            end
            OP_IMM: begin
                res = alu_model(ins[14:12], ins[30], 1'b0, a, imm_i);
                we  = 1'b1;
            end
            OP_LUI: begin
                res = {ins[31:12], 12'h000};
                we  = 1'b1;
            end
            OP_AUIPC: begin
                res = m_pc + {ins[31:12], 12'h000};
                we  = 1'b1;
            end
            OP_JAL: begin
                res = m_pc + 4;
                we  = 1'b1;
                npc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OP_JALR: begin
                res = m_pc + 4;
                we  = 1'b1;
                npc = (a + imm_i) & ~32'd1;
            end
            OP_BR: begin
                if (branch_taken(ins[14:12], a, b)) begin
                    npc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: begin
            end
        endcase
        we = we && (rd != 5'd0); // x0 is never written
        check_value("retire_pc", m_pc, retire_pc);
        check_value("retire_we", word_t'(we), word_t'(retire_we));
        if (we) begin
            check_value("retire_rd", word_t'(rd), word_t'(retire_rd));
            check_value("retire_data", res, retire_data);
            m_regs[rd] = res;
        end
        m_pc = npc;
    endtask

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("The run did not retire %0d instructions within %0d cycles",
                 RETIRE_TARGET, CYCLE_LIMIT);
        $display("TEST FAILED");
        $fatal(1, "Timeout");
    end

    initial begin : assert_watch
        wait (u_dut.u_assert.fail_count != 0);
        $display("A bound assertion on the core failed");
        $display("TEST FAILED");
        $fatal(1, "Assertion failure");
    end

    initial begin : stimulus
        int    retired;
        int    pause_left;
        word_t r;
        rst_n      = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        retired    = 0;
        pause_left = 0;
        build_program();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = word_t'(i);
            imem_wdata = prog[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
        m_pc    = '0;
        for (int k = 0; k < 32; k++) begin
            m_regs[k] = '0;
        end
        while (retired < RETIRE_TARGET) begin
            @(negedge clk);
            check_value("retire_valid", word_t'(run), word_t'(retire_valid)); // Run at last edge
            if (retire_valid) begin
                check_retirement();
                retired++;
            end
            r = next_random();
            if (pause_left > 0) begin
                pause_left--;
                run = 1'b0;
            end else if (r[4:0] == 5'd0) begin
                pause_left = int'(r[9:8]); // Window of 1 to 4 cycles
                run        = 1'b0;
            end else begin
                run = 1'b1;
            end
        end
        @(negedge clk);
        run = 1'b0;
        if (u_dut.u_assert.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("A bound assertion on the core failed");
            $display("TEST FAILED");
            $fatal(1, "Assertion failure");
        end
    end

endmodule

//--- project.f
rv_pkg.sv
fetch_unit.sv
inst_decoder.sv
reg_file.sv
alu.sv
branch_unit.sv
rv_core.sv
rv_core_assert.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - rv_pkg.sv
      - fetch_unit.sv
      - inst_decoder.sv
      - reg_file.sv
      - alu.sv
      - branch_unit.sv
      - rv_core.sv
  - target: test
    files:
      - rv_core_assert.sv
      - tb_rv_core.sv
